// File: tb.f
ooo_pkg.sv
ooo_ifs.sv
dispatch_unit.sv
phys_regfile.sv
reservation_station.sv
alu_unit.sv
mul_unit.sv
rob.sv
ooo_core.sv
ooo_core_asserts.sv
tb_ooo_core.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only on the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_ooo_core -o sim_ooo
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_ooo +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
    exit 0
fi
exit 1

// File: tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core;

    localparam int          MUL_LATENCY    = 3;
    localparam int          NUM_PROLOGUE   = 10;
    localparam int          NUM_RANDOM     = 200;
    localparam int          NUM_BURST      = 8;
    localparam int          TIMEOUT_CYCLES =
        (NUM_PROLOGUE + NUM_RANDOM + NUM_BURST) * (MUL_LATENCY + 20);
    localparam logic [31:0] SEED           = 32'h24f8_86a1;
    localparam logic [6:0]  OP_R           = 7'b0110011;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        stall;
    logic        commit_valid;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;

    logic [31:0] arch_regs [32];  // sequential reference state
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    logic        exp_empty;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    logic        drained;
    int          accept_count = 0;
    int          commit_count = 0;
    int          cycle_count  = 0;

    ooo_core #(.MUL_LATENCY(MUL_LATENCY)) UUT (
        .clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst(inst), .stall(stall),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_data(commit_data)
    );

    bind ooo_core ooo_core_asserts u_chk (
        .clk(clk), .rst_n(rst_n), .stall(stall), .commit_valid(commit_valid),
        .commit_rd(commit_rd), .commit_data(commit_data),
        .exp_empty(tb_ooo_core.exp_empty), .exp_rd(tb_ooo_core.exp_rd),
        .exp_data(tb_ooo_core.exp_data), .drained(tb_ooo_core.drained)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    // returns 0 for words that never reach the ROB
    function automatic logic model_result(input logic [31:0] w, input logic [31:0] a,
                                          input logic [31:0] b, output logic [31:0] res);
        res = '0;
        if (w[6:0] != OP_R)
            return 1'b0;
        case ({w[31:25], w[14:12]})
            {7'h00, 3'b000}: res = a + b;
            {7'h20, 3'b000}: res = a - b;
            {7'h00, 3'b111}: res = a & b;
            {7'h00, 3'b110}: res = a | b;
            {7'h00, 3'b100}: res = a ^ b;
            {7'h00, 3'b010}: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            {7'h01, 3'b000}: res = a * b;  // low word
            default:         return 1'b0;
        endcase
        return 1'b1;
    endfunction

    function automatic logic [31:0] random_word();
        int unsigned roll;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        roll = $urandom_range(99);
        rd   = 5'($urandom_range(7));
        rs1  = 5'($urandom_range(7));
        rs2  = 5'($urandom_range(7));
        if (roll < 30)
            return encode_r(7'h01, 3'b000, rd, rs1, rs2);
        if (roll < 33)
            return {25'($urandom()), 7'b0010011};  // OP-IMM is dropped
        if (roll < 35)
            return encode_r(7'h20, 3'b111, rd, rs1, rs2);  // undefined funct
        case (roll % 6)
            0:       return encode_r(7'h00, 3'b000, rd, rs1, rs2);
            1:       return encode_r(7'h20, 3'b000, rd, rs1, rs2);
            2:       return encode_r(7'h00, 3'b111, rd, rs1, rs2);
            3:       return encode_r(7'h00, 3'b110, rd, rs1, rs2);
            4:       return encode_r(7'h00, 3'b100, rd, rs1, rs2);
            default: return encode_r(7'h00, 3'b010, rd, rs1, rs2);
        endcase
    endfunction

    task automatic refresh_head();
        exp_empty = (exp_rd_q.size() == 0);
        exp_rd    = exp_empty ? 5'd0 : exp_rd_q[0];
        exp_data  = exp_empty ? 32'd0 : exp_data_q[0];
    endtask

    task automatic record_accept(input logic [31:0] w);
        logic [31:0] res;
        if (model_result(w, arch_regs[w[19:15]], arch_regs[w[24:20]], res)) begin
            exp_rd_q.push_back(w[11:7]);
            exp_data_q.push_back(res);
            if (w[11:7] != 5'd0)
                arch_regs[w[11:7]] = res;
            accept_count++;
            refresh_head();
        end
    endtask

    // entered and left 1 ns after a rising edge
    task automatic send_word(input logic [31:0] w);
        logic taken;
        taken      = 1'b0;
        inst_valid = 1'b1;
        inst       = w;
        while (!taken) begin
            @(negedge clk);
            taken = !stall;
            @(posedge clk);
            #1;
        end
        record_accept(w);
        inst_valid = 1'b0;
    endtask

    // retire side of the reference queue
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && commit_valid) begin
                @(posedge clk);
                #1;
                if (exp_rd_q.size() != 0) begin
                    void'(exp_rd_q.pop_front());
                    void'(exp_data_q.pop_front());
                end
                commit_count++;
                refresh_head();
            end
        end
    end

    always @(negedge clk) begin
        if (UUT.u_chk.fail_count != 0) begin
            $display("Simulation FAILED");
            $fatal(1, "a checker assertion failed");
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(SEED));
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        drained    = 1'b0;
        for (int i = 0; i < 32; i++)
            arch_regs[i] = 32'(i);  // xN holds N out of reset
        refresh_head();
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        send_word(encode_r(7'h01, 3'b000, 5'd1, 5'd2, 5'd3));
        send_word(encode_r(7'h00, 3'b000, 5'd2, 5'd1, 5'd1));
        send_word(encode_r(7'h20, 3'b000, 5'd3, 5'd0, 5'd2));
        send_word(encode_r(7'h00, 3'b100, 5'd4, 5'd3, 5'd5));
        send_word(encode_r(7'h00, 3'b010, 5'd5, 5'd3, 5'd2));
        send_word(encode_r(7'h00, 3'b110, 5'd6, 5'd4, 5'd7));
        send_word(encode_r(7'h00, 3'b111, 5'd7, 5'd6, 5'd2));
        send_word(encode_r(7'h01, 3'b000, 5'd1, 5'd1, 5'd3));
        send_word(encode_r(7'h00, 3'b000, 5'd0, 5'd1, 5'd2));  // write to x0
        send_word(encode_r(7'h00, 3'b000, 5'd6, 5'd0, 5'd5));  // read of x0

        for (int n = 0; n < NUM_RANDOM; n++) begin
            send_word(random_word());
            if ($urandom_range(9) == 0) begin  // occasional bubble
                @(posedge clk);
                #1;
            end
        end

        // dependent multiply chain on x1
        for (int n = 0; n < NUM_BURST; n++)
            send_word(encode_r(7'h01, 3'b000, 5'd1, 5'd1, 5'(n % 3 + 1)));

        while (commit_count != accept_count) begin
            @(posedge clk);
            #2;
        end
        drained = 1'b1;
        repeat (20) @(posedge clk);
        #2;

        if (commit_count == accept_count && exp_empty && UUT.u_chk.fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("ERROR commit_count %h expected %h", commit_count, accept_count);
            $display("Simulation FAILED");
            $fatal(1, "commit count mismatch after drain");
        end
    end

endmodule

// File: ooo_core_asserts.sv
`timescale 1ns/1ps

module ooo_core_asserts (
    input logic               clk,
    input logic               rst_n,
    input logic               stall,
    input logic               commit_valid,
    input ooo_pkg::arch_reg_t commit_rd,
    input ooo_pkg::data_t     commit_data,
    input logic               exp_empty,
    input ooo_pkg::arch_reg_t exp_rd,
    input ooo_pkg::data_t     exp_data,
    input logic               drained
);
    int fail_count = 0;

    a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !commit_valid && !stall)
        else begin
            fail_count++;
            $error("ERROR commit_valid %h stall %h after reset, expected 0 and 0",
                   $sampled(commit_valid), $sampled(stall));
        end

    // every commit must match an accepted instruction
    a_commit_has_entry: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> !exp_empty)
        else begin
            fail_count++;
            $error("a commit happened with no accepted instruction outstanding");
        end

    a_commit_rd: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid && !exp_empty |-> commit_rd == exp_rd)
        else begin
            fail_count++;
            $error("ERROR commit_rd %h expected %h", $sampled(commit_rd), $sampled(exp_rd));
        end

    a_commit_data: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid && !exp_empty |-> commit_data == exp_data)
        else begin
            fail_count++;
            $error("ERROR commit_data %h expected %h", $sampled(commit_data),
                   $sampled(exp_data));
        end

    a_no_extra_commit: assert property (@(posedge clk) disable iff (!rst_n)
        drained |-> !commit_valid)
        else begin
            fail_count++;
            $error("a commit happened after all accepted instructions had retired");
        end

endmodule

// File: ooo_core.sv
`timescale 1ns/1ps

module ooo_core #(
    parameter int ROB_DEPTH    = 16,
    parameter int ALU_RS_DEPTH = 4,
    parameter int MUL_RS_DEPTH = 2,
    parameter int MUL_LATENCY  = 3
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               inst_valid,
    input  ooo_pkg::inst_t     inst,
    output logic               stall,
    output logic               commit_valid,
    output ooo_pkg::arch_reg_t commit_rd,
    output ooo_pkg::data_t     commit_data
);
    import ooo_pkg::*;

    dispatch_if d_alu ();
    dispatch_if d_mul ();
    issue_if    i_alu ();
    issue_if    i_mul ();
    wb_if       wb_alu ();
    wb_if       wb_mul ();

    phys_tag_t rs1_tag, rs2_tag, alloc_tag, alloc_old_tag, free_tag;
    data_t     rs1_val, rs2_val;
    logic      rs1_ready, rs2_ready, alloc_tag_valid;
    logic      alloc, rob_full, free_valid, rs_alu_full, rs_mul_full;
    arch_reg_t alloc_rd;
    rob_idx_t  alloc_idx;

    dispatch_unit u_dispatch (
        .clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst(inst), .stall(stall),
        .rs1_tag(rs1_tag), .rs2_tag(rs2_tag), .rs1_ready(rs1_ready), .rs2_ready(rs2_ready),
        .rs1_val(rs1_val), .rs2_val(rs2_val),
        .alloc_tag(alloc_tag), .alloc_tag_valid(alloc_tag_valid),
        .alloc(alloc), .alloc_rd(alloc_rd), .alloc_old_tag(alloc_old_tag),
        .alloc_idx(alloc_idx), .rob_full(rob_full),
        .free_valid(free_valid), .free_tag(free_tag),
        .rs_alu_full(rs_alu_full), .rs_mul_full(rs_mul_full),
        .d_alu(d_alu), .d_mul(d_mul)
    );

    phys_regfile u_prf (
        .clk(clk), .rst_n(rst_n), .rs1_tag(rs1_tag), .rs2_tag(rs2_tag),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .rs1_ready(rs1_ready), .rs2_ready(rs2_ready),
        .alloc_tag(alloc_tag), .alloc_tag_valid(alloc_tag_valid),
        .wb_alu(wb_alu), .wb_mul(wb_mul)
    );

    reservation_station #(.DEPTH(ALU_RS_DEPTH)) u_rs_alu (
        .clk(clk), .rst_n(rst_n), .din(d_alu), .wb_alu(wb_alu), .wb_mul(wb_mul),
        .iss(i_alu), .full(rs_alu_full)
    );

    reservation_station #(.DEPTH(MUL_RS_DEPTH)) u_rs_mul (
        .clk(clk), .rst_n(rst_n), .din(d_mul), .wb_alu(wb_alu), .wb_mul(wb_mul),
        .iss(i_mul), .full(rs_mul_full)
    );

    alu_unit u_alu (.clk(clk), .rst_n(rst_n), .iss(i_alu), .wb(wb_alu));

    mul_unit #(.MUL_LATENCY(MUL_LATENCY)) u_mul (
        .clk(clk), .rst_n(rst_n), .iss(i_mul), .wb(wb_mul)
    );

    rob #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clk(clk), .rst_n(rst_n), .alloc(alloc), .alloc_rd(alloc_rd),
        .alloc_old_tag(alloc_old_tag), .alloc_idx(alloc_idx), .full(rob_full),
        .wb_alu(wb_alu), .wb_mul(wb_mul),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_data(commit_data),
        .free_valid(free_valid), .free_tag(free_tag)
    );

endmodule

// File: rob.sv
`timescale 1ns/1ps

module rob #(
    parameter int ROB_DEPTH = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               alloc,
    input  ooo_pkg::arch_reg_t alloc_rd,
    input  ooo_pkg::phys_tag_t alloc_old_tag,
    output ooo_pkg::rob_idx_t  alloc_idx,
    output logic               full,
    wb_if.snoop                wb_alu,
    wb_if.snoop                wb_mul,
    output logic               commit_valid,
    output ooo_pkg::arch_reg_t commit_rd,
    output ooo_pkg::data_t     commit_data,
    output logic               free_valid,
    output ooo_pkg::phys_tag_t free_tag
);
    import ooo_pkg::*;

    arch_reg_t                        rd_q   [ROB_DEPTH];
    phys_tag_t                        old_q  [ROB_DEPTH];
    data_t                            val_q  [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]             done_q;
    rob_idx_t                         head, tail;
    logic [$clog2(ROB_DEPTH+1)-1:0]   count;

    function automatic rob_idx_t incr(rob_idx_t p);
        return (p == rob_idx_t'(ROB_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign alloc_idx    = tail;
    assign full         = (count == ROB_DEPTH);
    assign commit_valid = (count != '0) && done_q[head];
    assign commit_rd    = rd_q[head];
    assign commit_data  = val_q[head];
    assign free_valid   = commit_valid && (rd_q[head] != '0);  // x0 holds no tag
    assign free_tag     = old_q[head];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            done_q <= '0;
        end else begin
            if (alloc) begin
                rd_q[tail]   <= alloc_rd;
                old_q[tail]  <= alloc_old_tag;
                done_q[tail] <= 1'b0;
                tail         <= incr(tail);
            end
            if (wb_alu.valid) begin
                done_q[wb_alu.rob_idx] <= 1'b1;
                val_q[wb_alu.rob_idx]  <= wb_alu.data;
            end
            if (wb_mul.valid) begin
                done_q[wb_mul.rob_idx] <= 1'b1;
                val_q[wb_mul.rob_idx]  <= wb_mul.data;
            end
            if (commit_valid)
                head <= incr(head);
            count <= count + alloc - commit_valid;
        end
    end

endmodule

// File: mul_unit.sv
`timescale 1ns/1ps

module mul_unit #(
    parameter int MUL_LATENCY = 3
) (
    input  logic clk,
    input  logic rst_n,
    issue_if.dst iss,
    wb_if.src    wb
);
    import ooo_pkg::*;

    logic [MUL_LATENCY-1:0] vld_q;
    phys_tag_t              tag_q  [MUL_LATENCY];
    rob_idx_t               idx_q  [MUL_LATENCY];
    data_t                  prod_q [MUL_LATENCY];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= iss.valid;
            for (int s = 1; s < MUL_LATENCY; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0]  <= iss.dst_tag;
        idx_q[0]  <= iss.rob_idx;
        prod_q[0] <= iss.a * iss.b;  // low word only
        for (int s = 1; s < MUL_LATENCY; s++) begin
            tag_q[s]  <= tag_q[s-1];
            idx_q[s]  <= idx_q[s-1];
            prod_q[s] <= prod_q[s-1];
        end
    end

    assign wb.valid   = vld_q[MUL_LATENCY-1];
    assign wb.dst_tag = tag_q[MUL_LATENCY-1];
    assign wb.rob_idx = idx_q[MUL_LATENCY-1];
    assign wb.data    = prod_q[MUL_LATENCY-1];

endmodule

// File: alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic clk,
    input  logic rst_n,
    issue_if.dst iss,
    wb_if.src    wb
);
    import ooo_pkg::*;

    data_t result;

    always_comb begin
        case (iss.op)
            ALU_SUB: result = iss.a - iss.b;
            ALU_AND: result = iss.a & iss.b;
            ALU_OR:  result = iss.a | iss.b;
            ALU_XOR: result = iss.a ^ iss.b;
            ALU_SLT: result = data_t'($signed(iss.a) < $signed(iss.b));
            default: result = iss.a + iss.b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            wb.valid <= 1'b0;
        else
            wb.valid <= iss.valid;
    end

    always_ff @(posedge clk) begin
        wb.dst_tag <= iss.dst_tag;
        wb.rob_idx <= iss.rob_idx;
        wb.data    <= result;
    end

endmodule

// File: reservation_station.sv
`timescale 1ns/1ps

module reservation_station #(
    parameter int DEPTH = 4
) (
    input  logic    clk,
    input  logic    rst_n,
    dispatch_if.dst din,
    wb_if.snoop     wb_alu,
    wb_if.snoop     wb_mul,
    issue_if.src    iss,
    output logic    full
);
    import ooo_pkg::*;

    localparam int SW = $clog2(DEPTH);

    logic [DEPTH-1:0] valid_q, rdy1_q, rdy2_q;
    alu_op_e          op_q   [DEPTH];
    phys_tag_t        tag1_q [DEPTH];
    phys_tag_t        tag2_q [DEPTH];
    data_t            val1_q [DEPTH];
    data_t            val2_q [DEPTH];
    phys_tag_t        dst_q  [DEPTH];
    rob_idx_t         idx_q  [DEPTH];

    logic [SW-1:0] ins_slot, iss_slot;
    logic          iss_hit;

    // wakeup on either result bus
    function automatic logic [XLEN:0] capture(logic rdy, data_t val, phys_tag_t tag);
        if (!rdy && wb_alu.valid && wb_alu.dst_tag == tag)
            return {1'b1, wb_alu.data};
        if (!rdy && wb_mul.valid && wb_mul.dst_tag == tag)
            return {1'b1, wb_mul.data};
        return {rdy, val};
    endfunction

    always_comb begin
        ins_slot = '0;
        iss_slot = '0;
        iss_hit  = 1'b0;
        for (int i = DEPTH - 1; i >= 0; i--) begin  // downward so lowest slot wins
            if (!valid_q[i])
                ins_slot = SW'(i);
            if (valid_q[i] && rdy1_q[i] && rdy2_q[i]) begin
                iss_slot = SW'(i);
                iss_hit  = 1'b1;
            end
        end
    end

    assign full        = &valid_q;
    assign iss.valid   = iss_hit;
    assign iss.op      = op_q[iss_slot];
    assign iss.a       = val1_q[iss_slot];
    assign iss.b       = val2_q[iss_slot];
    assign iss.dst_tag = dst_q[iss_slot];
    assign iss.rob_idx = idx_q[iss_slot];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                {rdy1_q[i], val1_q[i]} <= capture(rdy1_q[i], val1_q[i], tag1_q[i]);
                {rdy2_q[i], val2_q[i]} <= capture(rdy2_q[i], val2_q[i], tag2_q[i]);
            end
            if (iss_hit)
                valid_q[iss_slot] <= 1'b0;
            if (din.valid) begin
                valid_q[ins_slot] <= 1'b1;
                op_q[ins_slot]    <= din.op;
                tag1_q[ins_slot]  <= din.src1_tag;
                tag2_q[ins_slot]  <= din.src2_tag;
                dst_q[ins_slot]   <= din.dst_tag;
                idx_q[ins_slot]   <= din.rob_idx;
                {rdy1_q[ins_slot], val1_q[ins_slot]} <=
                    capture(din.src1_ready, din.src1_val, din.src1_tag);
                {rdy2_q[ins_slot], val2_q[ins_slot]} <=
                    capture(din.src2_ready, din.src2_val, din.src2_tag);
            end
        end
    end

endmodule

// File: phys_regfile.sv
`timescale 1ns/1ps

module phys_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  ooo_pkg::phys_tag_t rs1_tag,
    input  ooo_pkg::phys_tag_t rs2_tag,
    output ooo_pkg::data_t     rs1_val,
    output ooo_pkg::data_t     rs2_val,
    output logic               rs1_ready,
    output logic               rs2_ready,
    input  ooo_pkg::phys_tag_t alloc_tag,
    input  logic               alloc_tag_valid,
    wb_if.snoop                wb_alu,
    wb_if.snoop                wb_mul
);
    import ooo_pkg::*;

    data_t               regs [NUM_PHYS];
    logic [NUM_PHYS-1:0] ready_q;

    // {ready, value} with same-cycle results forwarded
    function automatic logic [XLEN:0] read_port(phys_tag_t tag);
        if (tag == '0)
            return {1'b1, {XLEN{1'b0}}};
        if (wb_alu.valid && wb_alu.dst_tag == tag)
            return {1'b1, wb_alu.data};
        if (wb_mul.valid && wb_mul.dst_tag == tag)
            return {1'b1, wb_mul.data};
        return {ready_q[tag], regs[tag]};
    endfunction

    assign {rs1_ready, rs1_val} = read_port(rs1_tag);
    assign {rs2_ready, rs2_val} = read_port(rs2_tag);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_q <= '1;
            // xN comes out of reset holding N
            for (int i = 0; i < NUM_PHYS; i++) begin
                regs[i] <= data_t'(i);
            end
        end else begin
            if (alloc_tag_valid)
                ready_q[alloc_tag] <= 1'b0;
            if (wb_alu.valid) begin
                ready_q[wb_alu.dst_tag] <= 1'b1;
                regs[wb_alu.dst_tag]    <= wb_alu.data;
            end
            if (wb_mul.valid) begin
                ready_q[wb_mul.dst_tag] <= 1'b1;
                regs[wb_mul.dst_tag]    <= wb_mul.data;
            end
        end
    end

endmodule

// File: dispatch_unit.sv
`timescale 1ns/1ps

module dispatch_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               inst_valid,
    input  ooo_pkg::inst_t     inst,
    output logic               stall,
    output ooo_pkg::phys_tag_t rs1_tag,
    output ooo_pkg::phys_tag_t rs2_tag,
    input  logic               rs1_ready,
    input  logic               rs2_ready,
    input  ooo_pkg::data_t     rs1_val,
    input  ooo_pkg::data_t     rs2_val,
    output ooo_pkg::phys_tag_t alloc_tag,
    output logic               alloc_tag_valid,
    output logic               alloc,
    output ooo_pkg::arch_reg_t alloc_rd,
    output ooo_pkg::phys_tag_t alloc_old_tag,
    input  ooo_pkg::rob_idx_t  alloc_idx,
    input  logic               rob_full,
    input  logic               free_valid,
    input  ooo_pkg::phys_tag_t free_tag,
    input  logic               rs_alu_full,
    input  logic               rs_mul_full,
    dispatch_if.src            d_alu,
    dispatch_if.src            d_mul
);
    import ooo_pkg::*;

    phys_tag_t  map_q [32];      // rename table
    phys_tag_t  fl_q  [32];      // circular free list
    logic [4:0] fl_head, fl_tail;

    alu_op_e   op;
    logic      is_op, is_mul, accept;
    arch_reg_t rd, rs1, rs2;
    phys_tag_t dst_tag;

    assign rd  = inst[11:7];
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];

    always_comb begin
        op    = ALU_ADD;
        is_op = (inst[6:0] == OPCODE_OP);
        case ({inst[31:25], inst[14:12]})
            {7'b0000000, 3'b000}:    op = ALU_ADD;
            {7'b0100000, 3'b000}:    op = ALU_SUB;
            {7'b0000000, 3'b111}:    op = ALU_AND;
            {7'b0000000, 3'b110}:    op = ALU_OR;
            {7'b0000000, 3'b100}:    op = ALU_XOR;
            {7'b0000000, 3'b010}:    op = ALU_SLT;
            {FUNCT7_MULDIV, 3'b000}: op = ALU_MUL;
            default:                 is_op = 1'b0;  // dropped before the ROB
        endcase
    end

    assign is_mul = (op == ALU_MUL);
    assign stall  = rob_full || (is_op && (is_mul ? rs_mul_full : rs_alu_full));
    assign accept = inst_valid && !stall;

    assign rs1_tag         = map_q[rs1];
    assign rs2_tag         = map_q[rs2];
    assign alloc_tag       = fl_q[fl_head];
    assign alloc_tag_valid = accept && is_op && (rd != '0);
    assign alloc           = accept && is_op;
    assign alloc_rd        = rd;
    assign alloc_old_tag   = map_q[rd];
    assign dst_tag         = (rd != '0) ? alloc_tag : '0;  // x0 results go to tag 0

    assign d_alu.valid      = alloc && !is_mul;
    assign d_mul.valid      = alloc && is_mul;
    assign d_alu.op         = op;
    assign d_mul.op         = op;
    assign d_alu.src1_tag   = rs1_tag;
    assign d_mul.src1_tag   = rs1_tag;
    assign d_alu.src2_tag   = rs2_tag;
    assign d_mul.src2_tag   = rs2_tag;
    assign d_alu.src1_ready = rs1_ready;
    assign d_mul.src1_ready = rs1_ready;
    assign d_alu.src2_ready = rs2_ready;
    assign d_mul.src2_ready = rs2_ready;
    assign d_alu.src1_val   = rs1_val;
    assign d_mul.src1_val   = rs1_val;
    assign d_alu.src2_val   = rs2_val;
    assign d_mul.src2_val   = rs2_val;
    assign d_alu.dst_tag    = dst_tag;
    assign d_mul.dst_tag    = dst_tag;
    assign d_alu.rob_idx    = alloc_idx;
    assign d_mul.rob_idx    = alloc_idx;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                map_q[i] <= phys_tag_t'(i);       // identity map
                fl_q[i]  <= phys_tag_t'(32 + i);
            end
            fl_head <= '0;
            fl_tail <= '0;
        end else begin
            if (alloc_tag_valid) begin
                map_q[rd] <= alloc_tag;
                fl_head   <= fl_head + 1'b1;
            end
            if (free_valid) begin
                fl_q[fl_tail] <= free_tag;
                fl_tail       <= fl_tail + 1'b1;
            end
        end
    end

endmodule

// File: ooo_ifs.sv
`timescale 1ns/1ps

interface dispatch_if;
    import ooo_pkg::*;

    logic      valid;
    alu_op_e   op;
    phys_tag_t src1_tag;
    phys_tag_t src2_tag;
    logic      src1_ready;
    logic      src2_ready;
    data_t     src1_val;
    data_t     src2_val;
    phys_tag_t dst_tag;
    rob_idx_t  rob_idx;

    modport src (output valid, op, src1_tag, src2_tag, src1_ready, src2_ready,
                 output src1_val, src2_val, dst_tag, rob_idx);
    modport dst (input valid, op, src1_tag, src2_tag, src1_ready, src2_ready,
                 input src1_val, src2_val, dst_tag, rob_idx);
endinterface

interface issue_if;
    import ooo_pkg::*;

    logic      valid;
    alu_op_e   op;
    data_t     a;
    data_t     b;
    phys_tag_t dst_tag;
    rob_idx_t  rob_idx;

    modport src (output valid, op, a, b, dst_tag, rob_idx);
    modport dst (input valid, op, a, b, dst_tag, rob_idx);
endinterface

interface wb_if;
    import ooo_pkg::*;

    logic      valid;
    phys_tag_t dst_tag;
    rob_idx_t  rob_idx;
    data_t     data;

    modport src   (output valid, dst_tag, rob_idx, data);
    modport snoop (input valid, dst_tag, rob_idx, data);
endinterface

// File: ooo_pkg.sv
package ooo_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_PHYS = 64;

    typedef logic [XLEN-1:0] data_t;
    typedef logic [4:0]      arch_reg_t;
    typedef logic [5:0]      phys_tag_t;  // tag 0 is the hardwired zero
    typedef logic [3:0]      rob_idx_t;
    typedef logic [31:0]     inst_t;

    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] FUNCT7_MULDIV = 7'd1;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_MUL
    } alu_op_e;

endpackage
